// ==== bench/weight_mm_cases.txt ====
# Per line: 16 weights row-major W[r][c], 4 vector elements x[0..3],
# 4 expected column sums y[c] = sum over r of x[r] * W[r][c]. Decimal.
1 0 0 0 0 1 0 0 0 0 1 0 0 0 0 1 1 2 3 4 1 2 3 4
255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 260100 260100 260100 260100
0 1 2 3 4 5 6 7 8 9 10 11 12 13 14 15 1 1 1 1 24 28 32 36
0 1 2 3 4 5 6 7 8 9 10 11 12 13 14 15 0 0 0 1 12 13 14 15
1 2 3 4 5 6 7 8 9 10 11 12 13 14 15 16 2 0 1 3 50 56 62 68
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 9 9 9 9 0 0 0 0
10 0 0 200 0 20 100 0 0 50 30 0 255 0 0 1 3 4 5 6 1560 330 550 606
255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 0 0 1 65280 65280 65280 65280

// ==== src.f ====
logic/mm_pkg.sv
logic/bram.sv
logic/weight_loader.sv
logic/mat_vec_engine.sv
logic/weight_mm_top.sv
bench/weight_mm_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module weight_mm_tb -f src.f -o weight_mm_sim

# The simulator exits non-zero on failure; the log decides the verdict.
./obj_dir/weight_mm_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "Simulation ended without a verdict"
  exit 1
fi
echo "Simulation passed"

// ==== bench/weight_mm_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module weight_mm_tb;

  import mm_pkg::*;

  localparam int MAX_CASES = 32;

  //********************
  // DUT signals
  //********************
  logic        clk;
  logic        rst_n;
  logic        w_wr_en;
  store_addr_t w_wr_addr;
  data_t       w_wr_data;
  logic        x_wr_en;
  row_idx_t    x_wr_sel;
  data_t       x_wr_data;
  logic        load_req;
  logic        load_ack;
  logic        calc_req;
  logic        calc_ack;
  col_idx_t    y_sel;
  acc_t        y_data;

  int          w_mem [MAX_CASES][NUM_WEIGHTS];  // Row-major weights per case.
  int          x_mem [MAX_CASES][NUM_ROWS];
  int          y_exp [MAX_CASES][NUM_COLS];
  int          prev_y [NUM_COLS];               // Results of the last compute.
  int          num_cases;
  int          cycle_count;
  int          cycle_limit;
  logic [31:0] lcg_state;

  weight_mm_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .w_wr_en   (w_wr_en),
    .w_wr_addr (w_wr_addr),
    .w_wr_data (w_wr_data),
    .x_wr_en   (x_wr_en),
    .x_wr_sel  (x_wr_sel),
    .x_wr_data (x_wr_data),
    .load_req  (load_req),
    .load_ack  (load_ack),
    .calc_req  (calc_req),
    .calc_ack  (calc_ack),
    .y_sel     (y_sel),
    .y_data    (y_data)
  );

  always #50 clk = ~clk;  // 100 ns period.

  // Run limit.
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: simulation ran %0d cycles without finishing", cycle_count);
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  //********************
  // Helpers
  //********************
  function automatic int random_gap();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'((lcg_state >> 16) & 32'd7);  // 0 to 7 idle cycles.
  endfunction

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s, got %0d, expected %0d", $time, msg, actual, expected);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  // Next edge, then inputs move 1 ns later.
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_gap();
    int n;
    n = random_gap();
    repeat (n) step();
  endtask

  task automatic check_results(input string msg);
    for (int c = 0; c < NUM_COLS; c++) begin
      y_sel = col_idx_t'(c);
      #1;
      check_eq(32'(y_data), prev_y[c], $sformatf("%s, column %0d", msg, c));
    end
  endtask

  task automatic read_cases();
    int    fd;
    int    r;
    int    v [24];
    string line;
    fd = $fopen("bench/weight_mm_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the cases file bench/weight_mm_cases.txt");
      $display("=== FAIL ===");
      $fatal(1);
    end
    num_cases = 0;
    while (!$feof(fd) && num_cases < MAX_CASES) begin
      line = "";
      r = $fgets(line, fd);
      if (line.len() > 1 && line.getc(0) != "#") begin
        r = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                    v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15],
                    v[16], v[17], v[18], v[19], v[20], v[21], v[22], v[23]);
        if (r == 24) begin
          for (int i = 0; i < NUM_WEIGHTS; i++) w_mem[num_cases][i] = v[i];
          for (int i = 0; i < NUM_ROWS; i++) x_mem[num_cases][i] = v[16 + i];
          for (int i = 0; i < NUM_COLS; i++) y_exp[num_cases][i] = v[20 + i];
          num_cases++;
        end
      end
    end
    $fclose(fd);
  endtask

  //********************
  // Handshakes
  //********************
  // Raise req, time the ack, hold over a gap, then release.
  task automatic run_load();
    int n;
    idle_gap();
    load_req = 1'b1;
    step();                                // First edge that sees the request.
    n = 0;
    while (!load_ack) begin
      step();
      n++;
    end
    check_eq(n, NUM_WEIGHTS + 2, "load_ack latency");
    n = random_gap();
    repeat (n) begin
      step();
      check_eq(32'(load_ack), 1, "load_ack held");
    end
    load_req = 1'b0;
    step();
    check_eq(32'(load_ack), 0, "load_ack release");
  endtask

  task automatic run_calc();
    int n;
    idle_gap();
    calc_req = 1'b1;
    step();
    n = 0;
    while (!calc_ack) begin
      step();
      n++;
    end
    check_eq(n, NUM_ROWS + 1, "calc_ack latency");
    check_results("result");
    n = random_gap();
    repeat (n) begin
      step();
      check_eq(32'(calc_ack), 1, "calc_ack held");
      check_results("result under back-pressure");
    end
    calc_req = 1'b0;
    step();
    check_eq(32'(calc_ack), 0, "calc_ack release");
    check_results("result after release");
  endtask

  //********************
  // Main sequence
  //********************
  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    w_wr_en     = 1'b0;
    w_wr_addr   = '0;
    w_wr_data   = '0;
    x_wr_en     = 1'b0;
    x_wr_sel    = '0;
    x_wr_data   = '0;
    load_req    = 1'b0;
    calc_req    = 1'b0;
    y_sel       = '0;
    cycle_count = 0;
    cycle_limit = 50;
    lcg_state   = 32'd32;
    for (int c = 0; c < NUM_COLS; c++) prev_y[c] = 0;

    read_cases();
    cycle_limit = num_cases * 80 + 50;

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step();
    check_eq(32'(load_ack), 0, "load_ack after reset");
    check_eq(32'(calc_ack), 0, "calc_ack after reset");
    check_results("result after reset");

    for (int k = 0; k < num_cases; k++) begin
      for (int i = 0; i < NUM_WEIGHTS; i++) begin
        w_wr_en   = 1'b1;
        w_wr_addr = store_addr_t'(i);
        w_wr_data = data_t'(w_mem[k][i]);
        step();
      end
      w_wr_en = 1'b0;
      run_load();
      for (int r = 0; r < NUM_ROWS; r++) begin
        x_wr_en   = 1'b1;
        x_wr_sel  = row_idx_t'(r);
        x_wr_data = data_t'(x_mem[k][r]);
        step();
      end
      x_wr_en = 1'b0;
      check_results("old result after new weights and vector");  // Must still hold.
      for (int c = 0; c < NUM_COLS; c++) prev_y[c] = y_exp[k][c];
      run_calc();
    end

    if (num_cases > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("No cases were read from the cases file");
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/weight_mm_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module weight_mm_top (
  input  wire logic                clk,
  input  wire logic                rst_n,
  // Weight store writes, row-major.
  input  wire logic                w_wr_en,
  input  wire mm_pkg::store_addr_t w_wr_addr,
  input  wire mm_pkg::data_t       w_wr_data,
  // Input vector writes.
  input  wire logic                x_wr_en,
  input  wire mm_pkg::row_idx_t    x_wr_sel,
  input  wire mm_pkg::data_t       x_wr_data,
  // Handshakes.
  input  wire logic                load_req,
  output logic                     load_ack,
  input  wire logic                calc_req,
  output logic                     calc_ack,
  // Result read.
  input  wire mm_pkg::col_idx_t    y_sel,
  output mm_pkg::acc_t             y_data
);

  import mm_pkg::*;

  store_addr_t             store_rd_addr;
  data_t                   store_rd_data;
  row_idx_t                col_rd_row;
  data_t [NUM_COLS-1:0]    col_rd_data;   // One word per column RAM.

  //********************
  // Weight store
  //********************
  bram #(
    .DEPTH      (NUM_WEIGHTS),
    .ADDR_W     (STORE_ADDR_W),
    .WIDTH      (DATA_W),
    .RD_LATENCY (1)
  ) weight_store_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (w_wr_en),
    .wr_addr (w_wr_addr),
    .wr_data (w_wr_data),
    .rd_addr (store_rd_addr),
    .rd_data (store_rd_data)
  );

  // Scatter into the column RAMs.
  weight_loader loader_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_req      (load_req),
    .load_ack      (load_ack),
    .store_rd_addr (store_rd_addr),
    .store_rd_data (store_rd_data),
    .col_rd_row    (col_rd_row),
    .col_rd_data   (col_rd_data)
  );

  mat_vec_engine engine_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .x_wr_en     (x_wr_en),
    .x_wr_sel    (x_wr_sel),
    .x_wr_data   (x_wr_data),
    .calc_req    (calc_req),
    .calc_ack    (calc_ack),
    .col_rd_row  (col_rd_row),
    .col_rd_data (col_rd_data),
    .y_sel       (y_sel),
    .y_data      (y_data)
  );

endmodule

`default_nettype wire

// ==== logic/mat_vec_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module mat_vec_engine (
  input  wire logic                                     clk,
  input  wire logic                                     rst_n,
  // Input vector writes.
  input  wire logic                                     x_wr_en,
  input  wire mm_pkg::row_idx_t                         x_wr_sel,
  input  wire mm_pkg::data_t                            x_wr_data,
  // Four-phase compute handshake.
  input  wire logic                                     calc_req,
  output logic                                          calc_ack,
  // Column RAM reads.
  output mm_pkg::row_idx_t                              col_rd_row,
  input  wire mm_pkg::data_t [mm_pkg::NUM_COLS-1:0]     col_rd_data,
  // Result select.
  input  wire mm_pkg::col_idx_t                         y_sel,
  output mm_pkg::acc_t                                  y_data
);

  import mm_pkg::*;

  //********************
  // Declarations
  //********************
  engine_state_t                     state_q;
  row_idx_t                          row_q;     // Row being accumulated.
  logic                              last_row;
  data_t                             x_q [NUM_ROWS];
  acc_t                              acc_q [NUM_COLS];
  logic [NUM_COLS-1:0][2*DATA_W-1:0] prod;      // Full-width products.

  assign col_rd_row = row_q;
  assign last_row   = (row_q == row_idx_t'(NUM_ROWS - 1));
  assign y_data     = acc_q[y_sel];               // Read straight from the sums.

  //********************
  // Input vector
  //********************
  // Writes are ignored while a row walk is under way.
  always_ff @(posedge clk) begin
    if (x_wr_en && (state_q != EN_RUN)) begin
      x_q[x_wr_sel] <= x_wr_data;
    end
  end

  //********************
  // Control FSM
  //********************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= EN_IDLE;
      row_q    <= '0;
      calc_ack <= 1'b0;
    end else begin
      calc_ack <= (state_q == EN_DONE) && calc_req;

      case (state_q)
        EN_IDLE: begin
          if (calc_req) begin
            state_q <= EN_RUN;
            row_q   <= '0;
          end
        end

        EN_RUN: begin
          row_q <= row_q + 1'b1;    // One row per cycle.
          if (last_row) begin
            state_q <= EN_DONE;
          end
        end

        EN_DONE: begin
          if (!calc_req) begin
            state_q <= EN_IDLE;
          end
        end

        default: state_q <= EN_IDLE;
      endcase
    end
  end

  //********************
  // Multiply-accumulate
  //********************
  always_comb begin
    for (int c = 0; c < NUM_COLS; c++) begin
      prod[c] = x_q[row_q] * col_rd_data[c];
    end
  end

  // Sums clear on a new request and hold once the walk ends.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        acc_q[c] <= '0;
      end
    end else if ((state_q == EN_IDLE) && calc_req) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        acc_q[c] <= '0;
      end
    end else if (state_q == EN_RUN) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        acc_q[c] <= acc_q[c] + acc_t'(prod[c]);
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/weight_loader.sv ====
`timescale 1ns/1ns
`default_nettype none

module weight_loader (
  input  wire logic                                     clk,
  input  wire logic                                     rst_n,
  // Four-phase load handshake.
  input  wire logic                                     load_req,
  output logic                                          load_ack,
  // Weight store read port.
  output mm_pkg::store_addr_t                           store_rd_addr,
  input  wire mm_pkg::data_t                            store_rd_data,
  // Column RAM read side, driven by the engine.
  input  wire mm_pkg::row_idx_t                         col_rd_row,
  output mm_pkg::data_t [mm_pkg::NUM_COLS-1:0]          col_rd_data
);

  import mm_pkg::*;

  //********************
  // Declarations
  //********************
  loader_state_t       state_q;
  store_addr_t         addr_q;      // Store address on the read port.
  logic                issue_q;     // Addresses still being issued.
  logic                rd_valid_q;  // Store word valid, one cycle after issue.
  row_idx_t            row_q;       // Row of the word on store_rd_data.
  col_idx_t            col_q;       // Column of the word on store_rd_data.
  logic                last_wr;
  logic [NUM_COLS-1:0] col_wr_en;

  assign store_rd_addr = addr_q;

  // Final word of the matrix is being written this cycle.
  assign last_wr = rd_valid_q &&
                   (row_q == row_idx_t'(NUM_ROWS - 1)) &&
                   (col_q == col_idx_t'(NUM_COLS - 1));

  //********************
  // Column RAMs
  //********************
  generate
    for (genvar i = 0; i < NUM_COLS; i++) begin : g_col
      // Only the RAM of the current column takes the word.
      assign col_wr_en[i] = rd_valid_q && (col_q == col_idx_t'(i));

      bram #(
        .DEPTH      (NUM_ROWS),
        .ADDR_W     (ROW_W),
        .WIDTH      (DATA_W),
        .RD_LATENCY (0)
      ) col_ram_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (col_wr_en[i]),
        .wr_addr (row_q),
        .wr_data (store_rd_data),
        .rd_addr (col_rd_row),
        .rd_data (col_rd_data[i])
      );
    end
  endgenerate

  //********************
  // Copy FSM
  //********************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= LD_IDLE;
      addr_q     <= '0;
      issue_q    <= 1'b0;
      rd_valid_q <= 1'b0;
      row_q      <= '0;
      col_q      <= '0;
      load_ack   <= 1'b0;
    end else begin
      rd_valid_q <= issue_q;                              // Store read latency.
      load_ack   <= (state_q == LD_DONE) && load_req;     // Drops with req.

      case (state_q)
        LD_IDLE: begin
          if (load_req) begin
            state_q <= LD_COPY;
            addr_q  <= '0;
            issue_q <= 1'b1;
            row_q   <= '0;
            col_q   <= '0;
          end
        end

        LD_COPY: begin
          // Walk the store, one address per cycle.
          if (issue_q) begin
            if (addr_q == store_addr_t'(NUM_WEIGHTS - 1)) begin
              issue_q <= 1'b0;
            end else begin
              addr_q <= addr_q + 1'b1;
            end
          end
          // Row and column follow the returned words.
          if (rd_valid_q) begin
            if (col_q == col_idx_t'(NUM_COLS - 1)) begin
              col_q <= '0;
              row_q <= row_q + 1'b1;
            end else begin
              col_q <= col_q + 1'b1;
            end
          end
          if (last_wr) begin
            state_q <= LD_DONE;
          end
        end

        LD_DONE: begin
          if (!load_req) begin
            state_q <= LD_IDLE;                           // Requester released.
          end
        end

        default: state_q <= LD_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/bram.sv ====
`timescale 1ns/1ns
`default_nettype none

module bram #(
  parameter int DEPTH      = 16,
  parameter int ADDR_W     = 4,
  parameter int WIDTH      = 8,
  parameter int RD_LATENCY = 1   // 0 reads through, 1 adds an output register.
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              wr_en,
  input  wire logic [ADDR_W-1:0] wr_addr,
  input  wire logic [WIDTH-1:0]  wr_data,
  input  wire logic [ADDR_W-1:0] rd_addr,
  output logic      [WIDTH-1:0]  rd_data
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  generate
    if (RD_LATENCY == 0) begin : g_rd_comb
      assign rd_data = mem[rd_addr]; // Combinational read.
    end else begin : g_rd_reg
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          rd_data <= '0;
        end else begin
          rd_data <= mem[rd_addr];
        end
      end
    end
  endgenerate

endmodule

`default_nettype wire

// ==== logic/mm_pkg.sv ====
`default_nettype none

package mm_pkg;

  //********************
  // Matrix geometry.
  //********************
  localparam int DATA_W       = 8;                    // Weight and vector element.
  localparam int ACC_W        = 20;                   // Column sum.
  localparam int NUM_ROWS     = 4;
  localparam int NUM_COLS     = 4;
  localparam int NUM_WEIGHTS  = NUM_ROWS * NUM_COLS;
  localparam int STORE_ADDR_W = 4;
  localparam int ROW_W        = 2;
  localparam int COL_W        = 2;

  //********************
  // Vector types.
  //********************
  typedef logic [DATA_W-1:0]       data_t;
  typedef logic [ACC_W-1:0]        acc_t;
  // Store address is row * NUM_COLS + col, column index runs fastest.
  typedef logic [STORE_ADDR_W-1:0] store_addr_t;
  typedef logic [ROW_W-1:0]        row_idx_t;    // Also the column RAM address.
  typedef logic [COL_W-1:0]        col_idx_t;

  // Weight loader FSM.
  typedef enum logic [1:0] {
    LD_IDLE,
    LD_COPY,
    LD_DONE
  } loader_state_t;

  // Matrix-vector engine FSM.
  typedef enum logic [1:0] {
    EN_IDLE,
    EN_RUN,
    EN_DONE
  } engine_state_t;

endpackage

`default_nettype wire
